// ==== verilog.f ====
rtl/iwm_pkg.sv
rtl/drive_pkg.sv
rtl/iwm_soft_switches.sv
rtl/motor_inertia.sv
rtl/iwm_status.sv
rtl/iwm_top.sv
tb/tb_iwm.sv

// ==== tb/tb_iwm.sv ====
// Table driven testbench for the IWM soft switches, status byte and 5.25-inch spindle timing
`timescale 1ns/1ps

module tb_iwm;

    localparam time CLK_PERIOD   = 100;
    localparam time DRIVE_DLY    = 10;
    localparam int  RESET_CYCLES = 16;
    localparam int  SPINUP       = 40;
    localparam int  SPINDOWN     = 100;
    localparam int  TABLE_DEPTH  = 128;
    localparam logic RD = 1'b1;
    localparam logic WR = 1'b0;

    logic CLK_14M, RESET, PH2, DEVICE_SELECT, WR_CYCLE, WRITE_PROTECT, FLOPPY_MOTOR_ON;
    logic [15:0] A;
    logic [7:0]  D_IN, DISK35, D_OUT;
    logic [3:0]  DISK_READY;

    // One bus access with the drive inputs it runs under and the byte it should return
    typedef struct packed {
        logic [3:0] nib;
        logic       rd;
        logic [7:0] data;
        logic [7:0] disk35;
        logic [3:0] ready;
        logic       wp;
        logic       chk;
        logic [7:0] exp;
    } entry_t;

    entry_t      tbl [0:TABLE_DEPTH-1];
    int          n_tbl, checks, errors, tests, tests_bad, err_mark;
    logic [31:0] lfsr, rnd;
    logic [7:0]  env_disk35, got;
    logic [3:0]  env_ready;
    logic        env_wp;
    logic [4:0]  mode_val;

    iwm_top #(.SPINUP_CYCLES(SPINUP), .SPINDOWN_CYCLES(SPINDOWN)) u_dut (
        .CLK_14M(CLK_14M), .RESET(RESET), .PH2(PH2), .DEVICE_SELECT(DEVICE_SELECT),
        .WR_CYCLE(WR_CYCLE), .A(A), .D_IN(D_IN), .DISK_READY(DISK_READY), .DISK35(DISK35),
        .WRITE_PROTECT(WRITE_PROTECT), .D_OUT(D_OUT), .FLOPPY_MOTOR_ON(FLOPPY_MOTOR_ON)
    );

    initial begin
        CLK_14M = 1'b0;
        forever #(CLK_PERIOD / 2) CLK_14M = ~CLK_14M;
    end

    // ========================================================================
    // Reference rules
    // ========================================================================

    // Galois form with the low bit handed out
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // Sony status lines are active low and the upper half of the table floats high
    function automatic logic sony_sense(input logic head, input logic [2:0] idx,
                                        input logic present, input logic wp);
        logic [3:0] line;
        line = {head, idx};
        if (line == drive_pkg::SENSE_IDX_DISK_IN || line == drive_pkg::SENSE_IDX_MOTOR)
            sony_sense = !present;
        else if (line == drive_pkg::SENSE_IDX_WP)
            sony_sense = !wp;
        else
            sony_sense = 1'b1;
    endfunction

    // Sense on top, bit 6 clear, motor in bit 5, mode below
    function automatic logic [7:0] status_expect(input logic sense, input logic motor,
                                                 input logic [4:0] mode);
        status_expect = {sense, 1'b0, motor, mode};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    // ========================================================================
    // Stimulus and checks
    // ========================================================================

    task automatic add_entry(input logic [3:0] nib, input logic rd, input logic [7:0] data,
                             input logic chk, input logic [7:0] exp);
        tbl[n_tbl] = {nib, rd, data, env_disk35, env_ready, env_wp, chk, exp};
        n_tbl++;
    endtask

    // Move the phases to the wanted index, then read status with the motor running
    // The last phase access already shows the new index and the status read the latched one
    task automatic queue_sense_read(input logic [2:0] idx, input logic present);
        logic [7:0] exp_byte;
        exp_byte = status_expect(sony_sense(env_disk35[7], idx, present, env_wp),
                                 1'b1, mode_val);
        add_entry({iwm_pkg::SW_PHASE0, idx[0]}, RD, 8'h00, 1'b0, 8'h00);
        add_entry({iwm_pkg::SW_PHASE1, idx[1]}, RD, 8'h00, 1'b0, 8'h00);
        add_entry({iwm_pkg::SW_PHASE2, idx[2]}, RD, 8'h00, 1'b1, exp_byte);
        add_entry(4'hE, RD, 8'h00, 1'b1, exp_byte);
    endtask

    // Select and PH2 stay up for two clocks and D_OUT is taken in the middle of the first
    task automatic bus_cycle(input entry_t e, output logic [7:0] rd_val);
        @(posedge CLK_14M);
        #DRIVE_DLY;
        A             = 16'hC0E0 | e.nib;
        WR_CYCLE      = e.rd;
        D_IN          = e.data;
        DISK35        = e.disk35;
        DISK_READY    = e.ready;
        WRITE_PROTECT = e.wp;
        DEVICE_SELECT = 1'b1;
        PH2           = 1'b1;
        @(negedge CLK_14M);
        rd_val = D_OUT;
        @(posedge CLK_14M);
        @(posedge CLK_14M);
        #DRIVE_DLY;
        DEVICE_SELECT = 1'b0;
        PH2           = 1'b0;
        WR_CYCLE      = RD;
    endtask

    task automatic check_byte(input logic [7:0] val, input logic [7:0] exp, input string what);
        checks++;
        assert (val === exp) else begin
            errors++;
            $display("Mismatch at time %0t: %s read %h, expected %h", $time, what, val, exp);
        end
    endtask

    task automatic apply_table(input string name);
        logic [7:0] rd_val;
        for (int i = 0; i < n_tbl; i++) begin
            bus_cycle(tbl[i], rd_val);
            if (tbl[i].chk)
                check_byte(rd_val, tbl[i].exp, $sformatf("%s entry %0d", name, i));
        end
        n_tbl = 0;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors > err_mark) tests_bad++;
        $display("test %s: %s (%0d errors)", name, (errors > err_mark) ? "bad" : "ok",
                 errors - err_mark);
        err_mark = errors;
    endtask

    // Counting starts at 2 since the access itself spans two clocks
    task automatic wait_motor_level(input logic level, input int min_cycles);
        int cycles;
        int limit;
        cycles = 2;
        limit  = 4 * (min_cycles + 2);
        while (FLOPPY_MOTOR_ON !== level && cycles < limit) begin
            @(posedge CLK_14M);
            #1;
            cycles++;
        end
        checks++;
        assert (FLOPPY_MOTOR_ON === level) else begin
            errors++;
            $display("Timeout: FLOPPY_MOTOR_ON never went to %0b within %0d cycles", level, limit);
        end
        checks++;
        assert (cycles >= min_cycles) else begin
            errors++;
            $display("Mismatch at time %0t: FLOPPY_MOTOR_ON went to %0b after %0d cycles, not %0d",
                     $time, level, cycles, min_cycles);
        end
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        RESET = 1'b1;
        PH2 = 1'b0;
        DEVICE_SELECT = 1'b0;
        WR_CYCLE = RD;
        A = 16'hC0E0;
        D_IN = 8'h00;
        DISK_READY = 4'h0;
        DISK35 = 8'h00;
        WRITE_PROTECT = 1'b0;
        n_tbl = 0;
        checks = 0;
        errors = 0;
        tests = 0;
        tests_bad = 0;
        err_mark = 0;
        lfsr = 32'hf6573536;
        env_disk35 = 8'h00;
        env_ready = 4'h0;
        env_wp = 1'b0;
        mode_val = 5'd0;
        repeat (RESET_CYCLES) @(posedge CLK_14M);
        #DRIVE_DLY RESET = 1'b0;

        // Reading $C0ED sets Q6 and shows the status byte straight away
        check_byte({7'd0, FLOPPY_MOTOR_ON}, 8'h00, "FLOPPY_MOTOR_ON after reset");
        add_entry(4'hD, RD, 8'h00, 1'b1, status_expect(1'b1, 1'b0, 5'd0));
        apply_table("reset state");
        finish_test("reset state");

        // The write to $C0EF itself reads idle since Q7 is high then
        // Upper data bits are set and must not reach the mode
        for (int k = 0; k < 4; k++) begin
            take_bits(5, rnd);
            mode_val = rnd[4:0];
            add_entry(4'hF, WR, {3'b111, mode_val}, 1'b1, iwm_pkg::READ_IDLE);
            add_entry(4'hE, RD, 8'h00, 1'b1, status_expect(1'b1, 1'b0, mode_val));
        end
        apply_table("mode writes");
        add_entry(4'h9, RD, 8'h00, 1'b1, status_expect(1'b0, 1'b1, mode_val));
        add_entry(4'hF, WR, {3'b111, ~mode_val}, 1'b1, iwm_pkg::READ_IDLE);
        add_entry(4'hE, RD, 8'h00, 1'b1, status_expect(1'b0, 1'b1, mode_val));
        add_entry(4'h8, RD, 8'h00, 1'b1, status_expect(1'b1, 1'b0, mode_val));
        apply_table("mode locked");
        finish_test("mode writes");

        // Data, handshake and Q6=Q7=1 reads all float high
        add_entry(4'h9, RD, 8'h00, 1'b1, status_expect(1'b0, 1'b1, mode_val));
        add_entry(4'h8, RD, 8'h00, 1'b1, status_expect(1'b1, 1'b0, mode_val));
        add_entry(4'hC, RD, 8'h00, 1'b1, iwm_pkg::READ_IDLE);
        add_entry(4'hF, RD, 8'h00, 1'b1, iwm_pkg::READ_IDLE);
        add_entry(4'hD, RD, 8'h00, 1'b1, iwm_pkg::READ_IDLE);
        add_entry(4'hE, RD, 8'h00, 1'b1, status_expect(1'b1, 1'b0, mode_val));
        apply_table("immediate motor");
        finish_test("immediate motor");

        // Drive 1 on the 3.5-inch port with a write protected disk in it
        env_disk35 = 8'h40;
        env_ready = 4'b0100;
        env_wp = 1'b1;
        add_entry(4'h9, RD, 8'h00, 1'b1, status_expect(1'b1, 1'b1, mode_val));
        apply_table("3.5 motor on");
        // A 3.5-inch drive with a disk in runs its spindle as soon as the motor is on
        check_byte({7'd0, FLOPPY_MOTOR_ON}, 8'h01, "FLOPPY_MOTOR_ON on a 3.5-inch drive");
        for (int k = 0; k < 16; k++) begin
            env_disk35 = k[3] ? 8'hC0 : 8'h40;
            queue_sense_read(k[2:0], 1'b1);
        end
        env_disk35 = 8'h40;
        env_ready = 4'b0000;
        queue_sense_read(3'd2, 1'b0);
        queue_sense_read(3'd4, 1'b0);
        queue_sense_read(3'd6, 1'b0);
        add_entry(4'h8, RD, 8'h00, 1'b1, status_expect(1'b1, 1'b0, mode_val));
        apply_table("3.5 sense table");
        finish_test("3.5 sense table");

        // The select access itself still reads the drive selected before it
        env_disk35 = 8'h00;
        env_ready = 4'b0000;
        env_wp = 1'b1;
        add_entry(4'h9, RD, 8'h00, 1'b1, status_expect(1'b1, 1'b1, mode_val));
        env_wp = 1'b0;
        add_entry(4'hE, RD, 8'h00, 1'b1, status_expect(1'b0, 1'b1, mode_val));
        add_entry(4'hB, RD, 8'h00, 1'b1, status_expect(1'b0, 1'b1, mode_val));
        add_entry(4'hE, RD, 8'h00, 1'b1, status_expect(1'b1, 1'b1, mode_val));
        env_wp = 1'b1;
        add_entry(4'hE, RD, 8'h00, 1'b1, status_expect(1'b1, 1'b1, mode_val));
        add_entry(4'hA, RD, 8'h00, 1'b1, status_expect(1'b1, 1'b1, mode_val));
        add_entry(4'hE, RD, 8'h00, 1'b1, status_expect(1'b1, 1'b1, mode_val));
        env_wp = 1'b0;
        add_entry(4'hE, RD, 8'h00, 1'b1, status_expect(1'b0, 1'b1, mode_val));
        add_entry(4'h8, RD, 8'h00, 1'b1, status_expect(1'b1, 1'b0, mode_val));
        apply_table("5.25 sense");
        finish_test("5.25 sense");

        // Motor on a 5.25-inch drive, then off again after it reached speed
        check_byte({7'd0, FLOPPY_MOTOR_ON}, 8'h00, "FLOPPY_MOTOR_ON before spin-up");
        bus_cycle({4'h9, RD, 8'h00, 8'h00, 4'h0, 1'b0, 1'b0, 8'h00}, got);
        check_byte(got, status_expect(1'b0, 1'b1, mode_val), "motor on access");
        wait_motor_level(1'b1, SPINUP + 2);
        bus_cycle({4'h8, RD, 8'h00, 8'h00, 4'h0, 1'b0, 1'b0, 8'h00}, got);
        check_byte(got, status_expect(1'b1, 1'b0, mode_val), "motor off access");
        wait_motor_level(1'b0, SPINDOWN + 2);
        finish_test("motor inertia");

        $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 tests, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== rtl/iwm_top.sv ====
// IWM floppy controller top level joining the soft switches, the spindle timer and the status path
`timescale 1ns/1ps

module iwm_top #(
    parameter logic [drive_pkg::SPIN_CNT_W-1:0] SPINUP_CYCLES   = drive_pkg::SPINUP_DEFAULT,
    parameter logic [drive_pkg::SPIN_CNT_W-1:0] SPINDOWN_CYCLES = drive_pkg::SPINDOWN_DEFAULT
) (
    input  logic        CLK_14M,
    input  logic        RESET,
    input  logic        PH2,
    input  logic        DEVICE_SELECT,
    input  logic        WR_CYCLE,
    input  logic [15:0] A,
    input  logic [7:0]  D_IN,
    input  logic [3:0]  DISK_READY,
    input  logic [7:0]  DISK35,
    input  logic        WRITE_PROTECT,
    output logic [7:0]  D_OUT,
    output logic        FLOPPY_MOTOR_ON
);

    logic                          motor_on;
    logic                          motor_now;
    logic                          drive_sel;
    logic                          q6_now;
    logic                          q7_now;
    logic [iwm_pkg::MODE_BITS-1:0] mode_now;
    logic [2:0]                    sense_idx_now;
    logic                          spin_525;

    // Only the low nibble of the address reaches the chip
    // The stepper phases would go to a head mechanism, which is not modeled
    iwm_soft_switches u_switches (
        .CLK_14M       (CLK_14M),
        .RESET         (RESET),
        .PH2           (PH2),
        .DEVICE_SELECT (DEVICE_SELECT),
        .WR_CYCLE      (WR_CYCLE),
        .a_low         (A[3:0]),
        .d_in          (D_IN[iwm_pkg::MODE_BITS-1:0]),
        .phases        (),
        .motor_on      (motor_on),
        .motor_now     (motor_now),
        .drive_sel     (drive_sel),
        .q6_now        (q6_now),
        .q7_now        (q7_now),
        .mode_now      (mode_now),
        .sense_idx_now (sense_idx_now)
    );

    // Drive type comes straight from the 3.5-inch select bit
    motor_inertia #(
        .SPINUP_CYCLES   (SPINUP_CYCLES),
        .SPINDOWN_CYCLES (SPINDOWN_CYCLES)
    ) u_inertia (
        .CLK_14M  (CLK_14M),
        .RESET    (RESET),
        .motor_on (motor_on),
        .is_35    (DISK35[6]),
        .spin_525 (spin_525)
    );

    iwm_status u_status (
        .motor_now       (motor_now),
        .drive_sel       (drive_sel),
        .q6_now          (q6_now),
        .q7_now          (q7_now),
        .mode_now        (mode_now),
        .sense_idx_now   (sense_idx_now),
        .disk35          (DISK35[7:6]),
        .disk_ready      (DISK_READY),
        .write_protect   (WRITE_PROTECT),
        .spin_525        (spin_525),
        .d_out           (D_OUT),
        .floppy_motor_on (FLOPPY_MOTOR_ON)
    );

endmodule

// ==== rtl/iwm_status.sv ====
// IWM status path that picks the sense line for the selected drive and builds the read byte
`timescale 1ns/1ps

module iwm_status (
    input  logic                          motor_now,
    input  logic                          drive_sel,
    input  logic                          q6_now,
    input  logic                          q7_now,
    input  logic [iwm_pkg::MODE_BITS-1:0] mode_now,
    input  logic [2:0]                    sense_idx_now,
    input  logic [7:6]                    disk35,
    input  logic [3:0]                    disk_ready,
    input  logic                          write_protect,
    input  logic                          spin_525,
    output logic [7:0]                    d_out,
    output logic                          floppy_motor_on
);

    // =========================================================================
    // Drive choice
    // =========================================================================

    logic                       is_35;
    logic                       head_sel;
    logic                       disk_present;
    logic [3:0]                 sense_idx;
    logic                       sense_35;
    logic                       sense_525;
    logic                       sense;
    logic [iwm_pkg::MODE_W-1:0] mode_bus;
    logic [7:0]                 status_byte;

    // Bit 6 of the disk register picks the 3.5-inch port and bit 7 its head line
    assign is_35    = disk35[6];
    assign head_sel = disk35[7];

    // Media presence of whichever drive the type and select bits point at
    always_comb begin
        if (is_35) begin
            disk_present = drive_sel ? disk_ready[drive_pkg::READY_35_D2]
                                     : disk_ready[drive_pkg::READY_35_D1];
        end else begin
            disk_present = drive_sel ? disk_ready[drive_pkg::READY_525_D2]
                                     : disk_ready[drive_pkg::READY_525_D1];
        end
    end

    // =========================================================================
    // Sense line
    // =========================================================================

    // Head select on top, latched phases below
    assign sense_idx = {head_sel, sense_idx_now};

    // Sony status lines are active low and unused indices float high
    always_comb begin
        case (sense_idx)
            drive_pkg::SENSE_IDX_DISK_IN: sense_35 = !disk_present;
            drive_pkg::SENSE_IDX_MOTOR:   sense_35 = !(motor_now && disk_present);
            drive_pkg::SENSE_IDX_WP:      sense_35 = !write_protect;
            default:                      sense_35 = 1'b1;
        endcase
    end

    // A 5.25-inch drive puts its write protect switch on the sense line
    // Drive 2 is never fitted and reads high
    assign sense_525 = drive_sel ? 1'b1 : write_protect;

    // With no drive enabled the sense input is pulled high
    assign sense = !motor_now ? 1'b1 : (is_35 ? sense_35 : sense_525);

    // =========================================================================
    // Read byte
    // =========================================================================

    // Mode in the low bits with the upper bits cleared
    assign mode_bus = {{(iwm_pkg::MODE_W - iwm_pkg::MODE_BITS){1'b0}}, mode_now};

    always_comb begin
        status_byte                          = mode_bus;
        status_byte[iwm_pkg::STAT_SENSE_BIT] = sense;
        status_byte[iwm_pkg::STAT_MOTOR_BIT] = motor_now;
    end

    // Q6 high with Q7 low selects the status register
    // Data, handshake and the write side all read as idle
    assign d_out = (q6_now && !q7_now) ? status_byte : iwm_pkg::READ_IDLE;

    // The 3.5-inch spindle follows the enable when a disk is in
    assign floppy_motor_on = spin_525 || (is_35 && motor_now && disk_present);

endmodule

// ==== rtl/motor_inertia.sv ====
// Spindle inertia timer that delays 5.25-inch spin-up and holds the motor through spin-down
`timescale 1ns/1ps

module motor_inertia #(
    parameter logic [drive_pkg::SPIN_CNT_W-1:0] SPINUP_CYCLES   = drive_pkg::SPINUP_DEFAULT,
    parameter logic [drive_pkg::SPIN_CNT_W-1:0] SPINDOWN_CYCLES = drive_pkg::SPINDOWN_DEFAULT
) (
    input  logic CLK_14M,
    input  logic RESET,
    input  logic motor_on,
    input  logic is_35,
    output logic spin_525
);

    // One counter serves both directions
    // It counts up toward spin-up while stopped and down toward stop while coasting
    logic [drive_pkg::SPIN_CNT_W-1:0] spin_cnt;

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            spin_525 <= 1'b0;
            spin_cnt <= '0;
        end else if (is_35) begin
            // The Sony drive spins itself up, so the 5.25-inch spindle stays idle
            spin_525 <= 1'b0;
            spin_cnt <= '0;
        end else if (motor_on) begin
            if (spin_525) begin
                // Up to speed, keep a full coast time ready for the next motor off
                spin_cnt <= SPINDOWN_CYCLES;
            end else if (spin_cnt >= SPINUP_CYCLES) begin
                spin_525 <= 1'b1;
                spin_cnt <= SPINDOWN_CYCLES;
            end else begin
                spin_cnt <= spin_cnt + 1'b1;
            end
        end else begin
            if (!spin_525) begin
                // Motor off before reaching speed, so spin-up restarts from zero
                spin_cnt <= '0;
            end else if (spin_cnt == '0) begin
                spin_525 <= 1'b0;
            end else begin
                spin_cnt <= spin_cnt - 1'b1;
            end
        end
    end

    // Spin-up only completes while the motor is enabled
    a_no_rise_when_off: assert property (@(posedge CLK_14M) disable iff (RESET)
        $rose(spin_525) |-> $past(motor_on));

endmodule

// ==== rtl/iwm_soft_switches.sv ====
// IWM soft switch block holding the touch switches, the mode register and the sense index
`timescale 1ns/1ps

module iwm_soft_switches (
    input  logic                          CLK_14M,
    input  logic                          RESET,
    input  logic                          PH2,
    input  logic                          DEVICE_SELECT,
    input  logic                          WR_CYCLE,
    input  logic [3:0]                    a_low,
    input  logic [iwm_pkg::MODE_BITS-1:0] d_in,
    output logic [3:0]                    phases,
    output logic                          motor_on,
    output logic                          motor_now,
    output logic                          drive_sel,
    output logic                          q6_now,
    output logic                          q7_now,
    output logic [iwm_pkg::MODE_BITS-1:0] mode_now,
    output logic [2:0]                    sense_idx_now
);

    // =========================================================================
    // Access decode
    // =========================================================================

    logic [2:0]                    sel;
    logic                          new_val;
    logic                          cpu_wr;
    logic                          access_seen;
    logic                          access_edge;
    logic [3:0]                    phase_hit;
    logic                          phase_access;
    logic [3:0]                    phases_now;
    logic                          q6;
    logic                          q7;
    logic                          mode_write;
    logic [iwm_pkg::MODE_BITS-1:0] mode_reg;
    logic [2:0]                    sense_idx;
    logic [7:0]                    sw_vec;

    // The address selects a switch and its low bit is the value it takes
    assign sel     = a_low[3:1];
    assign new_val = a_low[0];

    // WR_CYCLE low during a selected cycle marks a CPU write
    assign cpu_wr = DEVICE_SELECT && !WR_CYCLE;

    // Only the first clock of a PH2-high access moves a switch
    assign access_edge = DEVICE_SELECT && PH2 && !access_seen;

    // One flag per stepper phase hit by the current access
    assign phase_hit[0] = DEVICE_SELECT && (sel == iwm_pkg::SW_PHASE0);
    assign phase_hit[1] = DEVICE_SELECT && (sel == iwm_pkg::SW_PHASE1);
    assign phase_hit[2] = DEVICE_SELECT && (sel == iwm_pkg::SW_PHASE2);
    assign phase_hit[3] = DEVICE_SELECT && (sel == iwm_pkg::SW_PHASE3);
    assign phase_access = |phase_hit;

    // =========================================================================
    // Immediate views
    // =========================================================================

    // A switch under access already shows its new level in this cycle
    assign phases_now = (phases & ~phase_hit) | (phase_hit & {4{new_val}});
    assign motor_now  = (DEVICE_SELECT && sel == iwm_pkg::SW_MOTOR) ? new_val : motor_on;
    assign q6_now     = (DEVICE_SELECT && sel == iwm_pkg::SW_Q6) ? new_val : q6;
    assign q7_now     = (DEVICE_SELECT && sel == iwm_pkg::SW_Q7) ? new_val : q7;

    // Mode writes need the motor off and Q6, Q7 high as they stand after this access
    // The odd address is what makes Q7 high when the write lands on $C0EF
    assign mode_write = cpu_wr && !motor_on && q6_now && q7_now && new_val;

    // The status read that follows a mode write sees the new mode at once
    assign mode_now = mode_write ? d_in : mode_reg;

    // A phase access moves the sense index within the same cycle
    assign sense_idx_now = phase_access ? phases_now[2:0] : sense_idx;

    // =========================================================================
    // Switch registers
    // =========================================================================

    always_ff @(posedge CLK_14M or posedge RESET) begin
        if (RESET) begin
            phases      <= 4'b0000;
            motor_on    <= 1'b0;
            drive_sel   <= 1'b0;
            q6          <= 1'b0;
            q7          <= 1'b0;
            mode_reg    <= '0;
            sense_idx   <= 3'b000;
            access_seen <= 1'b0;
        end else begin
            // Rearm once PH2 or the select drops so the next bus cycle counts again
            if (!PH2 || !DEVICE_SELECT) begin
                access_seen <= 1'b0;
            end

            if (access_edge) begin
                access_seen <= 1'b1;

                // Reads and writes both touch the switch, as on the real chip
                // Every phase access latches the index, set or clear alike
                if (phase_access) begin
                    phases    <= phases_now;
                    sense_idx <= phases_now[2:0];
                end

                case (sel)
                    iwm_pkg::SW_MOTOR:     motor_on  <= new_val;
                    iwm_pkg::SW_DRIVE_SEL: drive_sel <= new_val;
                    iwm_pkg::SW_Q6:        q6        <= new_val;
                    iwm_pkg::SW_Q7:        q7        <= new_val;
                    default: ;
                endcase

                if (mode_write) begin
                    mode_reg <= d_in;
                end
            end
        end
    end

    // =========================================================================
    // Checks
    // =========================================================================

    assign sw_vec = {phases, motor_on, drive_sel, q6, q7};

    // Each access moves one switch, so two levels never change on one edge
    a_one_switch: assert property (@(posedge CLK_14M) disable iff (RESET)
        $onehot0(sw_vec ^ $past(sw_vec)));

    // A running spindle locks the mode register
    a_mode_locked: assert property (@(posedge CLK_14M) disable iff (RESET)
        $changed(mode_reg) |-> !$past(motor_on));

endmodule

// ==== rtl/drive_pkg.sv ====
// Drive side constants for the ready bits, the 3.5-inch status lines and the spin timing
package drive_pkg;

    // =========================================================================
    // DISK_READY bit positions
    // =========================================================================

    // One ready bit per drive slot as reported by the storage block
    localparam int READY_525_D1 = 0;
    localparam int READY_525_D2 = 1;
    localparam int READY_35_D1  = 2;
    localparam int READY_35_D2  = 3;

    // =========================================================================
    // 3.5-inch status lines
    // =========================================================================

    // The Sony drive multiplexes its status onto the sense line
    // The index is the head select bit on top of the three latched phase bits
    // Low means a disk sits in the drive
    localparam logic [3:0] SENSE_IDX_DISK_IN = 4'd2;

    // Low means the spindle is turning
    localparam logic [3:0] SENSE_IDX_MOTOR   = 4'd4;

    // Low means the disk is write protected
    localparam logic [3:0] SENSE_IDX_WP      = 4'd6;

    // =========================================================================
    // 5.25-inch spindle timing
    // =========================================================================

    // Width of the shared spin-up and spin-down counter
    localparam int SPIN_CNT_W = 24;

    // About 300 ms of spin-up at 14 MHz
    localparam logic [SPIN_CNT_W-1:0] SPINUP_DEFAULT   = 24'd4200000;

    // About one second of coasting after the motor is switched off
    localparam logic [SPIN_CNT_W-1:0] SPINDOWN_DEFAULT = 24'd14000000;

endpackage

// ==== rtl/iwm_pkg.sv ====
// IWM register map constants for the soft switch selectors, the mode register and the status byte
package iwm_pkg;

    // =========================================================================
    // Soft switch selectors
    // =========================================================================

    // Address bits 3..1 pick one of the eight touch switches
    // Address bit 0 carries the level that the selected switch takes
    localparam logic [2:0] SW_PHASE0    = 3'd0;
    localparam logic [2:0] SW_PHASE1    = 3'd1;
    localparam logic [2:0] SW_PHASE2    = 3'd2;
    localparam logic [2:0] SW_PHASE3    = 3'd3;

    // Spindle motor enable at $C0E8/$C0E9
    localparam logic [2:0] SW_MOTOR     = 3'd4;

    // Drive 1 or drive 2 at $C0EA/$C0EB
    localparam logic [2:0] SW_DRIVE_SEL = 3'd5;

    // Q6 and Q7 together pick which internal register a read returns
    localparam logic [2:0] SW_Q6        = 3'd6;
    localparam logic [2:0] SW_Q7        = 3'd7;

    // =========================================================================
    // Mode register
    // =========================================================================

    // The chip keeps only the low five data bits of a mode write
    localparam int MODE_BITS = 5;

    // Seen from the bus the mode is a whole byte with its upper bits at zero
    localparam int MODE_W = 8;

    // =========================================================================
    // Status byte
    // =========================================================================

    // Sense line from the selected drive
    localparam int STAT_SENSE_BIT = 7;

    // Motor enable as the CPU sees it during the current access
    localparam int STAT_MOTOR_BIT = 5;

    // Data and handshake registers are not modeled, so they float to all ones
    localparam logic [7:0] READ_IDLE = 8'hFF;

endpackage
